// File: Bender.yml
package:
  name: glitc_fabric

sources:
  - files:
      - design/glitc_pkg.sv
      - design/glitcbus_slave.sv
      - design/glitcbus_decode.sv
      - design/glitc_control_regs.sv
      - design/glitc_sample_buffer.sv
      - design/glitc_debug_mux.sv
      - design/glitc_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_glitc_top.sv

// File: design/glitc_control_regs.sv
// GLITC control registers
`timescale 1ns/1ns

module glitc_control_regs import glitc_pkg::*; (
	input  logic                 gclk_i,
	input  logic                 rst_n_i,
	input  gb_req_t              req_i,
	input  logic                 sel_i,
	output logic [GB_DATA_W-1:0] rdat_o,
	output logic [2:0]           clock_ctrl_o,
	output logic                 glitc_reset_o,
	output logic                 hsk_update_o,
	output logic [1:0]           debug_sel_o
);

	logic [1:0]           offset;
	logic                 wr_en;
	logic [2:0]           clock_ctrl_q;
	logic [1:0]           debug_sel_q;
	logic                 reset_pulse_q;
	logic                 hsk_pulse_q;
	logic [GB_DATA_W-1:0] rdat_q;

	assign offset = req_i.adr[1:0];
	assign wr_en = req_i.wr && sel_i;

	//////////////////////////////
	// Writable fields and pulses
	//////////////////////////////
	always_ff @(posedge gclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			clock_ctrl_q <= '0;
			debug_sel_q <= '0;
			reset_pulse_q <= 1'b0;
			hsk_pulse_q <= 1'b0;
		end else begin
			// Pulses self-clear.
			reset_pulse_q <= 1'b0;
			hsk_pulse_q <= 1'b0;
			if (wr_en) begin
				case (offset)
					CTRL_PULSE: begin
						reset_pulse_q <= req_i.dat[0];
						hsk_pulse_q <= req_i.dat[1];
					end
					CTRL_CLOCK: clock_ctrl_q <= req_i.dat[2:0];
					CTRL_DEBUG: debug_sel_q <= req_i.dat[1:0];
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Readback
	//////////////////////////////
	always_ff @(posedge gclk_i) begin
		if (req_i.rd && sel_i) begin
			case (offset)
				CTRL_ID: rdat_q <= VERSION;
				CTRL_CLOCK: rdat_q <= {{(GB_DATA_W-3){1'b0}}, clock_ctrl_q};
				CTRL_DEBUG: rdat_q <= {{(GB_DATA_W-2){1'b0}}, debug_sel_q};
				default: rdat_q <= '0;
			endcase
		end
	end

	assign rdat_o = rdat_q;
	assign clock_ctrl_o = clock_ctrl_q;
	assign debug_sel_o = debug_sel_q;
	assign glitc_reset_o = reset_pulse_q;
	assign hsk_update_o = hsk_pulse_q;

	// One write strobe gives exactly one pulse cycle.
	assert property (@(posedge gclk_i) disable iff (!rst_n_i)
		glitc_reset_o |=> !glitc_reset_o);
	assert property (@(posedge gclk_i) disable iff (!rst_n_i)
		hsk_update_o |=> !hsk_update_o);

endmodule

// File: design/glitc_debug_mux.sv
// GLITC debug select
`timescale 1ns/1ns

module glitc_debug_mux import glitc_pkg::*; (
	input  logic               gclk_i,
	input  logic               rst_n_i,
	input  logic [1:0]         sel_i,
	input  gb_debug_t          dbg_i,
	input  logic [2:0]         clock_ctrl_i,
	output logic [DEBUG_W-1:0] debug_o
);

	logic [DEBUG_W-1:0] debug_q;

	always_ff @(posedge gclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			debug_q <= '0;
		end else begin
			case (sel_i)
				2'd0: debug_q <= dbg_i.last_adr;
				2'd1: debug_q <= dbg_i.last_wdat;
				2'd2: debug_q <= dbg_i.xfer_count;
				default: debug_q <= {{(DEBUG_W-3){1'b0}}, clock_ctrl_i};
			endcase
		end
	end

	assign debug_o = debug_q;

endmodule

// File: design/glitc_pkg.sv
// GLITC bus fabric definitions
package glitc_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////
	localparam int GB_ADDR_W = 16;
	localparam int GB_DATA_W = 32;
	localparam int GB_BYTE_W = 8;

	//////////////////////////////
	// Identification word
	//////////////////////////////
	localparam logic [3:0] VER_BOARDREV = 4'd0;
	localparam logic [3:0] VER_MONTH    = 4'd4;
	localparam logic [7:0] VER_DAY      = 8'd19;
	localparam logic [3:0] VER_MAJOR    = 4'd0;
	localparam logic [3:0] VER_MINOR    = 4'd6;
	localparam logic [7:0] VER_REV      = 8'd3;
	localparam logic [GB_DATA_W-1:0] VERSION = {VER_BOARDREV, VER_MONTH, VER_DAY,
		VER_MAJOR, VER_MINOR, VER_REV};

	//////////////////////////////
	// Address map
	//////////////////////////////
	// Bit 12 set selects sample storage, clear selects registers.
	localparam int SAMPLE_SEL_BIT = 12;
	// Register sub-space lives in bits 6 to 4.
	localparam int SUBSPACE_LSB = 4;
	localparam int SS_COUNT = 8;
	localparam int SS_W = $clog2(SS_COUNT);
	localparam logic [SS_W-1:0] SS_CTRL = '0;

	// Sample storage.
	localparam int SAMPLE_DEPTH = 1536;
	localparam int SAMPLE_ADDR_W = 11;

	// Control register offsets, address bits 1 to 0.
	localparam logic [1:0] CTRL_ID    = 2'd0;
	localparam logic [1:0] CTRL_PULSE = 2'd1;
	localparam logic [1:0] CTRL_CLOCK = 2'd2;
	localparam logic [1:0] CTRL_DEBUG = 2'd3;

	localparam int DEBUG_W = 16;

	//////////////////////////////
	// Local bus request
	//////////////////////////////
	typedef struct packed {
		logic [GB_ADDR_W-1:0] adr;
		logic [GB_DATA_W-1:0] dat;
		logic                 wr;
		logic                 rd;
	} gb_req_t;

	// Slave-side debug words.
	typedef struct packed {
		logic [GB_ADDR_W-1:0] last_adr;
		logic [DEBUG_W-1:0]   last_wdat;
		logic [15:0]          xfer_count;
	} gb_debug_t;

endpackage

// File: design/glitc_sample_buffer.sv
// GLITC sample storage
`timescale 1ns/1ns

module glitc_sample_buffer import glitc_pkg::*; (
	input  logic                 gclk_i,
	input  gb_req_t              req_i,
	input  logic                 sel_i,
	output logic [GB_DATA_W-1:0] rdat_o
);

	logic [GB_DATA_W-1:0]     mem_q [SAMPLE_DEPTH];
	logic [SAMPLE_ADDR_W-1:0] idx;
	logic                     in_range;
	logic [GB_DATA_W-1:0]     rdat_q;

	// 1536 words do not fill the 2k index space.
	assign idx = req_i.adr[SAMPLE_ADDR_W-1:0];
	assign in_range = (idx < SAMPLE_DEPTH);

	always_ff @(posedge gclk_i) begin
		if (req_i.wr && sel_i && in_range) begin
			mem_q[idx] <= req_i.dat;
		end
	end

	// Registered read of the held address.
	always_ff @(posedge gclk_i) begin
		if (in_range) begin
			rdat_q <= mem_q[idx];
		end else begin
			rdat_q <= '0;
		end
	end

	assign rdat_o = rdat_q;

endmodule

// File: design/glitc_top.sv
// GLITC register fabric top
`timescale 1ns/1ns

module glitc_top import glitc_pkg::*; (
	input  logic                 gclk_i,
	input  logic                 rst_n_i,
	input  logic                 gsel_b_i,
	input  logic                 grdwr_b_i,
	input  logic [GB_BYTE_W-1:0] gad_i,
	output logic [GB_BYTE_W-1:0] gad_o,
	output logic                 gad_oe_o,
	output logic [2:0]           clock_ctrl_o,
	output logic                 glitc_reset_o,
	output logic                 hsk_update_o,
	output logic [DEBUG_W-1:0]   debug_o
);

	gb_req_t              gb_req;
	gb_debug_t            gb_debug;
	logic [GB_DATA_W-1:0] gb_rdat;
	logic [GB_DATA_W-1:0] ctrl_dat;
	logic [GB_DATA_W-1:0] sample_dat;
	logic                 ctrl_sel;
	logic                 sample_sel;
	logic [1:0]           debug_sel;

	//////////////////////////////
	// Bus slave and decode
	//////////////////////////////
	glitcbus_slave u_slave (
		.gclk_i    (gclk_i),
		.rst_n_i   (rst_n_i),
		.gsel_b_i  (gsel_b_i),
		.grdwr_b_i (grdwr_b_i),
		.gad_i     (gad_i),
		.gad_o     (gad_o),
		.gad_oe_o  (gad_oe_o),
		.req_o     (gb_req),
		.rdat_i    (gb_rdat),
		.debug_o   (gb_debug)
	);

	glitcbus_decode u_decode (
		.gclk_i       (gclk_i),
		.req_i        (gb_req),
		.ctrl_dat_i   (ctrl_dat),
		.sample_dat_i (sample_dat),
		.ctrl_sel_o   (ctrl_sel),
		.sample_sel_o (sample_sel),
		.rdat_o       (gb_rdat)
	);

	//////////////////////////////
	// Targets
	//////////////////////////////
	glitc_control_regs u_control (
		.gclk_i        (gclk_i),
		.rst_n_i       (rst_n_i),
		.req_i         (gb_req),
		.sel_i         (ctrl_sel),
		.rdat_o        (ctrl_dat),
		.clock_ctrl_o  (clock_ctrl_o),
		.glitc_reset_o (glitc_reset_o),
		.hsk_update_o  (hsk_update_o),
		.debug_sel_o   (debug_sel)
	);

	glitc_sample_buffer u_samples (
		.gclk_i (gclk_i),
		.req_i  (gb_req),
		.sel_i  (sample_sel),
		.rdat_o (sample_dat)
	);

	// Debug word follows the control-register select.
	glitc_debug_mux u_debug_mux (
		.gclk_i       (gclk_i),
		.rst_n_i      (rst_n_i),
		.sel_i        (debug_sel),
		.dbg_i        (gb_debug),
		.clock_ctrl_i (clock_ctrl_o),
		.debug_o      (debug_o)
	);

endmodule

// File: design/glitcbus_decode.sv
// GLITCBUS address decode and readback
`timescale 1ns/1ns

module glitcbus_decode import glitc_pkg::*; (
	input  logic                 gclk_i,
	input  gb_req_t              req_i,
	input  logic [GB_DATA_W-1:0] ctrl_dat_i,
	input  logic [GB_DATA_W-1:0] sample_dat_i,
	output logic                 ctrl_sel_o,
	output logic                 sample_sel_o,
	output logic [GB_DATA_W-1:0] rdat_o
);

	logic            reg_space;
	logic [SS_W-1:0] ss_idx;
	logic [GB_DATA_W-1:0] ss_dat [SS_COUNT];

	// Register space is the lower 4k; bits 11 to 8 are don't-care.
	assign reg_space = !req_i.adr[SAMPLE_SEL_BIT];
	assign ss_idx = req_i.adr[SUBSPACE_LSB +: SS_W];

	assign ctrl_sel_o = reg_space && (ss_idx == SS_CTRL);
	assign sample_sel_o = req_i.adr[SAMPLE_SEL_BIT];

	//////////////////////////////
	// Readback mux
	//////////////////////////////
	always_comb begin
		// Only the control sub-space is populated.
		for (int i = 0; i < SS_COUNT; i++) begin
			ss_dat[i] = '0;
		end
		ss_dat[SS_CTRL] = ctrl_dat_i;
	end

	assign rdat_o = sample_sel_o ? sample_dat_i : ss_dat[ss_idx];

	// Targets must never both claim a strobe.
	assert property (@(posedge gclk_i) (req_i.wr || req_i.rd)
		|-> !(ctrl_sel_o && sample_sel_o));

endmodule

// File: design/glitcbus_slave.sv
// GLITCBUS byte-serial slave
`timescale 1ns/1ns

module glitcbus_slave import glitc_pkg::*; (
	input  logic                 gclk_i,
	input  logic                 rst_n_i,
	input  logic                 gsel_b_i,
	input  logic                 grdwr_b_i,
	input  logic [GB_BYTE_W-1:0] gad_i,
	output logic [GB_BYTE_W-1:0] gad_o,
	output logic                 gad_oe_o,
	output gb_req_t              req_o,
	input  logic [GB_DATA_W-1:0] rdat_i,
	output gb_debug_t            debug_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR_LO,
		ST_WDATA,
		ST_RWAIT,
		ST_RDOUT,
		ST_END
	} state_t;

	state_t               state_q;
	logic [1:0]           cnt_q;
	logic                 is_read_q;
	logic                 wr_q;
	logic                 rd_q;
	logic                 oe_q;
	logic [15:0]          xfer_count_q;
	logic [GB_ADDR_W-1:0] adr_q;
	logic [GB_DATA_W-1:0] dat_q;
	logic [GB_DATA_W-1:0] rd_shift_q;
	logic [GB_BYTE_W-1:0] gad_q;
	logic [GB_ADDR_W-1:0] last_adr_q;
	logic [DEBUG_W-1:0]   last_wdat_q;

	//////////////////////////////
	// Transaction FSM
	//////////////////////////////
	always_ff @(posedge gclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			cnt_q <= '0;
			is_read_q <= 1'b0;
			wr_q <= 1'b0;
			rd_q <= 1'b0;
			oe_q <= 1'b0;
			xfer_count_q <= '0;
		end else begin
			// Strobes and output enable are single-cycle unless re-asserted.
			wr_q <= 1'b0;
			rd_q <= 1'b0;
			oe_q <= 1'b0;
			if (gsel_b_i) begin
				// Deselect aborts whatever is in flight.
				state_q <= ST_IDLE;
				cnt_q <= '0;
			end else begin
				case (state_q)
					ST_IDLE: begin
						is_read_q <= grdwr_b_i;
						state_q <= ST_ADDR_LO;
					end
					ST_ADDR_LO: begin
						cnt_q <= '0;
						if (is_read_q) begin
							rd_q <= 1'b1;
							state_q <= ST_RWAIT;
						end else begin
							state_q <= ST_WDATA;
						end
					end
					ST_WDATA: begin
						cnt_q <= cnt_q + 2'd1;
						if (cnt_q == 2'd3) begin
							wr_q <= 1'b1;
							xfer_count_q <= xfer_count_q + 16'd1;
							state_q <= ST_END;
						end
					end
					ST_RWAIT: begin
						// Two edges for the target to settle its read word.
						cnt_q <= cnt_q + 2'd1;
						if (cnt_q == 2'd1) begin
							cnt_q <= '0;
							state_q <= ST_RDOUT;
						end
					end
					ST_RDOUT: begin
						oe_q <= 1'b1;
						cnt_q <= cnt_q + 2'd1;
						if (cnt_q == 2'd3) begin
							xfer_count_q <= xfer_count_q + 16'd1;
							state_q <= ST_END;
						end
					end
					default: begin
						// Wait here for the master to deselect.
						state_q <= ST_END;
					end
				endcase
			end
		end
	end

	//////////////////////////////
	// Byte shifting
	//////////////////////////////
	always_ff @(posedge gclk_i) begin
		if (!gsel_b_i) begin
			case (state_q)
				ST_IDLE: adr_q[GB_ADDR_W-1 -: GB_BYTE_W] <= gad_i;
				ST_ADDR_LO: adr_q[GB_BYTE_W-1:0] <= gad_i;
				ST_WDATA: begin
					dat_q <= {dat_q[GB_DATA_W-GB_BYTE_W-1:0], gad_i};
					if (cnt_q == 2'd3) begin
						last_adr_q <= adr_q;
						last_wdat_q <= {dat_q[GB_BYTE_W-1:0], gad_i};
					end
				end
				ST_RWAIT: begin
					if (cnt_q == 2'd1) begin
						rd_shift_q <= rdat_i;
					end
				end
				ST_RDOUT: begin
					// Most significant byte goes out first.
					gad_q <= rd_shift_q[GB_DATA_W-1 -: GB_BYTE_W];
					rd_shift_q <= rd_shift_q << GB_BYTE_W;
					if (cnt_q == 2'd3) begin
						last_adr_q <= adr_q;
					end
				end
				default: ;
			endcase
		end
	end

	assign req_o = '{adr: adr_q, dat: dat_q, wr: wr_q, rd: rd_q};
	assign gad_o = gad_q;
	assign gad_oe_o = oe_q;
	assign debug_o = '{last_adr: last_adr_q, last_wdat: last_wdat_q,
		xfer_count: xfer_count_q};

	// Only one kind of strobe per transaction.
	assert property (@(posedge gclk_i) disable iff (!rst_n_i)
		req_o.wr |-> !is_read_q);
	assert property (@(posedge gclk_i) disable iff (!rst_n_i)
		req_o.rd |-> is_read_q);

	// Read-out of a read begins three edges after its read strobe.
	assert property (@(posedge gclk_i) disable iff (!rst_n_i)
		$rose(gad_oe_o) |-> is_read_q && $past(rd_q, 3));

endmodule

// File: filelist.f
design/glitc_pkg.sv
design/glitcbus_slave.sv
design/glitcbus_decode.sv
design/glitc_control_regs.sv
design/glitc_sample_buffer.sv
design/glitc_debug_mux.sv
design/glitc_top.sv
tests/tb_clock_gen.sv
tests/tb_glitc_top.sv

// File: tests/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	// 10 ns period.
	initial begin
		clk_o = 1'b0;
		forever begin
			#5 clk_o = ~clk_o;
		end
	end

	// Reset held low for two rising edges.
	initial begin
		rst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

// File: tests/tb_glitc_top.sv
// GLITC fabric testbench
`timescale 1ns/1ns

module tb_glitc_top;

	logic        gclk;
	logic        rst_n;
	logic        gsel_b;
	logic        grdwr_b;
	logic [7:0]  gad_in;
	logic [7:0]  gad_out;
	logic        gad_oe;
	logic [2:0]  clock_ctrl;
	logic        glitc_reset;
	logic        hsk_update;
	logic [15:0] debug_word;

	logic [31:0] lfsr_q;
	int          checks;
	int          errors;
	int          tests_done;
	int          xfer_count;
	logic [2:0]  clock_model;

	tb_clock_gen u_clock (
		.clk_o   (gclk),
		.rst_n_o (rst_n)
	);

	glitc_top DUT (
		.gclk_i        (gclk),
		.rst_n_i       (rst_n),
		.gsel_b_i      (gsel_b),
		.grdwr_b_i     (grdwr_b),
		.gad_i         (gad_in),
		.gad_o         (gad_out),
		.gad_oe_o      (gad_oe),
		.clock_ctrl_o  (clock_ctrl),
		.glitc_reset_o (glitc_reset),
		.hsk_update_o  (hsk_update),
		.debug_o       (debug_word)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////
	// Board rev, month, day, major, minor, revision from the top.
	function automatic logic [31:0] expected_version();
		return {4'd0, 4'd4, 8'd19, 4'd0, 4'd6, 8'd3};
	endfunction

	// Taps 32, 22, 2, 1; one step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_done++;
		if (errors == errs_before) begin
			$display("Test %0d %s: passed", tests_done, name);
		end else begin
			$display("Test %0d %s: failed with %0d errors", tests_done, name,
				errors - errs_before);
		end
	endtask

	//////////////////////////////
	// Bus transactions
	//////////////////////////////
	// Fewer than four data bytes aborts the write by deselecting.
	task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
		input int nbytes);
		@(posedge gclk);
		#1;
		gsel_b = 1'b0;
		grdwr_b = 1'b0;
		gad_in = addr[15:8];
		@(posedge gclk);
		#1;
		gad_in = addr[7:0];
		for (int b = 0; b < nbytes; b++) begin
			@(posedge gclk);
			#1;
			gad_in = data[31 - 8*b -: 8];
		end
		@(posedge gclk);
		#1;
		gsel_b = 1'b1;
		grdwr_b = 1'b1;
		if (nbytes == 4) begin
			xfer_count++;
		end
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
		int waited;
		data = '0;
		@(posedge gclk);
		#1;
		gsel_b = 1'b0;
		grdwr_b = 1'b1;
		gad_in = addr[15:8];
		@(posedge gclk);
		#1;
		gad_in = addr[7:0];
		for (int b = 0; b < 4; b++) begin
			waited = 0;
			do begin
				@(posedge gclk);
				#1;
				waited++;
			end while (!gad_oe && waited < 10);
			if (!gad_oe) begin
				$display("Timeout: no read data byte %0d for address %h", b, addr);
				$display("Finished with errors");
				$finish;
			end
			data = {data[23:0], gad_out};
		end
		gsel_b = 1'b1;
		xfer_count++;
	endtask

	// Counts high cycles of both pulse outputs over a short window.
	task automatic count_pulses(output int n_reset, output int n_hsk);
		n_reset = 0;
		n_hsk = 0;
		repeat (6) begin
			@(posedge gclk);
			#1;
			n_reset += glitc_reset;
			n_hsk += hsk_update;
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic test_reset_and_id();
		logic [31:0] rd;
		int e0;
		e0 = errors;
		check_equal(gad_oe, 1'b0, "gad_oe_o after reset");
		check_equal(glitc_reset, 1'b0, "glitc_reset_o after reset");
		check_equal(hsk_update, 1'b0, "hsk_update_o after reset");
		check_equal(clock_ctrl, 3'd0, "clock_ctrl_o after reset");
		bus_read(16'h0000, rd);
		check_equal(rd, expected_version(), "version word");
		bus_read(16'h0003, rd);
		check_equal(rd, 32'd0, "debug select after reset");
		for (int s = 1; s < 8; s++) begin
			bus_read(16'(s << 4), rd);
			check_equal(rd, 32'd0, $sformatf("unused sub-space %0d", s));
		end
		report_test("reset and identification", e0);
	endtask

	task automatic test_clock_ctrl();
		logic [31:0] val;
		logic [31:0] rd;
		int e0;
		e0 = errors;
		repeat (4) begin
			val = rand_bits(32);
			bus_write(16'h0002, val, 4);
			clock_model = val[2:0];
			bus_read(16'h0002, rd);
			check_equal(rd, {29'd0, val[2:0]}, "clock control readback");
			check_equal(clock_ctrl, val[2:0], "clock_ctrl_o");
		end
		bus_write(16'h0000, 32'hffff_ffff, 4);
		bus_read(16'h0000, rd);
		check_equal(rd, expected_version(), "version after write");
		check_equal(clock_ctrl, clock_model, "clock_ctrl_o after ID write");
		report_test("clock control", e0);
	endtask

	task automatic test_pulses();
		int n_reset;
		int n_hsk;
		int e0;
		e0 = errors;
		bus_write(16'h0001, 32'h0000_0001, 4);
		count_pulses(n_reset, n_hsk);
		check_equal(n_reset, 1, "glitc_reset_o cycles");
		check_equal(n_hsk, 0, "hsk_update_o cycles on reset write");
		bus_write(16'h0001, 32'h0000_0002, 4);
		count_pulses(n_reset, n_hsk);
		check_equal(n_reset, 0, "glitc_reset_o cycles on update write");
		check_equal(n_hsk, 1, "hsk_update_o cycles");
		report_test("pulses", e0);
	endtask

	task automatic test_sample_buffer();
		logic [31:0] val;
		logic [31:0] rd;
		int idx;
		int e0;
		e0 = errors;
		repeat (8) begin
			idx = rand_bits(11) % 1536;
			val = rand_bits(32);
			bus_write(16'h1000 + 16'(idx), val, 4);
			bus_read(16'h1000 + 16'(idx), rd);
			check_equal(rd, val, $sformatf("sample word %0d", idx));
		end
		// Beyond the 1536 words of storage.
		bus_write(16'h1000 + 16'd1600, 32'hdead_beef, 4);
		bus_read(16'h1000 + 16'd1600, rd);
		check_equal(rd, 32'd0, "sample index 1600");
		report_test("sample buffer", e0);
	endtask

	task automatic test_debug_select();
		int e0;
		e0 = errors;
		bus_write(16'h0003, 32'h0000_0000, 4);
		repeat (2) @(posedge gclk);
		#1;
		check_equal(debug_word, 16'h0003, "debug last address");
		bus_write(16'h0003, 32'habcd_5a01, 4);
		repeat (2) @(posedge gclk);
		#1;
		check_equal(debug_word, 16'h5a01, "debug last write data");
		bus_write(16'h0003, 32'h0000_0002, 4);
		repeat (2) @(posedge gclk);
		#1;
		check_equal(debug_word, 16'(xfer_count), "debug transaction count");
		bus_write(16'h0003, 32'h0000_0003, 4);
		repeat (2) @(posedge gclk);
		#1;
		check_equal(debug_word, {13'd0, clock_model}, "debug clock control");
		report_test("debug select", e0);
	endtask

	task automatic test_abort();
		logic [31:0] rd;
		logic [2:0] newv;
		int e0;
		e0 = errors;
		newv = clock_model ^ 3'b101;
		bus_write(16'h0002, {29'd0, newv}, 2);
		repeat (3) @(posedge gclk);
		#1;
		check_equal(clock_ctrl, clock_model, "clock_ctrl_o after abort");
		bus_read(16'h0002, rd);
		check_equal(rd, {29'd0, clock_model}, "clock control after abort");
		bus_read(16'h0003, rd);
		check_equal(rd, 32'd3, "debug select after abort");
		bus_write(16'h0002, {29'd0, newv}, 4);
		clock_model = newv;
		bus_read(16'h0002, rd);
		check_equal(rd, {29'd0, newv}, "clock control after recovery");
		check_equal(clock_ctrl, newv, "clock_ctrl_o after recovery");
		report_test("aborted write", e0);
	endtask

	//////////////////////////////
	// Sequence
	//////////////////////////////
	initial begin
		int waited;
		gsel_b = 1'b1;
		grdwr_b = 1'b1;
		gad_in = 8'h00;
		lfsr_q = 32'h4047d6df;
		checks = 0;
		errors = 0;
		tests_done = 0;
		xfer_count = 0;
		clock_model = 3'd0;
		waited = 0;
		while (!rst_n && waited < 10) begin
			@(posedge gclk);
			waited++;
		end
		if (!rst_n) begin
			$display("Timeout: reset was never released");
			$display("Finished with errors");
			$finish;
		end
		@(posedge gclk);
		#1;
		test_reset_and_id();
		test_clock_ctrl();
		test_pulses();
		test_sample_buffer();
		test_debug_select();
		test_abort();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
